/* Bender.yml */
package:
  name: eeprom_master

dependencies: {}

sources:
  - rtl/eeprom_pkg.sv
  - rtl/i2c_cmd_if.sv
  - rtl/i2c_bit_engine.sv
  - rtl/eeprom_ctrl.sv
  - rtl/eeprom_master_top.sv
  - target: test
    files:
      - test/eeprom_model.sv
      - test/eeprom_checker.sv
      - test/tb_eeprom_master.sv

/* rtl/eeprom_ctrl.sv */
`timescale 1ns/10ps
module eeprom_ctrl (
  input  logic                          clk,
  input  logic                          rst_n,
  input  logic                          req,
  input  logic                          wr,
  input  logic [eeprom_pkg::ADDR_W-1:0] addr,
  input  logic [7:0]                    wdata,
  output logic                          ack,
  output logic [7:0]                    rdata,
  output logic                          nack,
  i2c_cmd_if.ctrl                       bus
);

  eeprom_pkg::ctrl_state_e state;
  eeprom_pkg::ctrl_state_e state_nxt;
  logic [2:0]              page;
  logic [7:0]              dev_sel;

  assign page    = addr[eeprom_pkg::ADDR_W-1 -: 3];
  assign dev_sel = {eeprom_pkg::EEPROM_DEV_ID, page, state == eeprom_pkg::DEV_R};

  always_comb begin
    state_nxt = state;
    case (state)
      eeprom_pkg::IDLE: begin
        if (req) state_nxt = eeprom_pkg::START_W;
      end
      eeprom_pkg::START_W: begin
        if (bus.done) state_nxt = eeprom_pkg::DEV_W;
      end
      eeprom_pkg::DEV_W: begin
        if (bus.done) begin
          state_nxt = bus.slave_nack ? eeprom_pkg::STOP : eeprom_pkg::WORD_ADDR;
        end
      end
      eeprom_pkg::WORD_ADDR: begin
        if (bus.done) begin
          if (bus.slave_nack) begin
            state_nxt = eeprom_pkg::STOP;
          end else if (wr) begin
            state_nxt = eeprom_pkg::DATA_W;
          end else begin
            state_nxt = eeprom_pkg::START_R;   // random read, dummy write done
          end
        end
      end
      eeprom_pkg::DATA_W: begin
        if (bus.done) state_nxt = eeprom_pkg::STOP;
      end
      eeprom_pkg::START_R: begin
        if (bus.done) state_nxt = eeprom_pkg::DEV_R;
      end
      eeprom_pkg::DEV_R: begin
        if (bus.done) begin
          state_nxt = bus.slave_nack ? eeprom_pkg::STOP : eeprom_pkg::DATA_R;
        end
      end
      eeprom_pkg::DATA_R: begin
        if (bus.done) state_nxt = eeprom_pkg::STOP;
      end
      eeprom_pkg::STOP: begin
        if (bus.done) state_nxt = eeprom_pkg::ACKN;
      end
      eeprom_pkg::ACKN: begin
        if (!req) state_nxt = eeprom_pkg::IDLE;
      end
      default: state_nxt = eeprom_pkg::IDLE;
    endcase
  end

  // command follows the state, valid whenever go is high
  always_comb begin
    bus.cmd     = eeprom_pkg::CMD_WRITE_BYTE;
    bus.tx_byte = dev_sel;
    case (state)
      eeprom_pkg::START_W,
      eeprom_pkg::START_R:   bus.cmd = eeprom_pkg::CMD_START;
      eeprom_pkg::WORD_ADDR: bus.tx_byte = addr[7:0];
      eeprom_pkg::DATA_W:    bus.tx_byte = wdata;
      eeprom_pkg::DATA_R:    bus.cmd = eeprom_pkg::CMD_READ_BYTE;
      eeprom_pkg::STOP,
      eeprom_pkg::IDLE,
      eeprom_pkg::ACKN:      bus.cmd = eeprom_pkg::CMD_STOP;
      default: ;
    endcase
  end

  assign bus.master_ack = 1'b1;  // single byte read ends with nack

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state  <= eeprom_pkg::IDLE;
      bus.go <= 1'b0;
      nack   <= 1'b0;
    end else begin
      state <= state_nxt;
      // one go per entry into a bus command state
      bus.go <= (state_nxt != state) &&
                (state_nxt != eeprom_pkg::IDLE) && (state_nxt != eeprom_pkg::ACKN);
      if (state == eeprom_pkg::IDLE && req) begin
        nack <= 1'b0;
      end else if (bus.done && bus.slave_nack) begin
        nack <= 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (state == eeprom_pkg::DATA_R && bus.done) begin
      rdata <= bus.rx_byte;
    end
  end

  assign ack = (state == eeprom_pkg::ACKN);

  // no second command until the engine reports back
  a_go_outstanding: assert property (@(posedge clk) disable iff (!rst_n)
    bus.go |=> !bus.go until bus.done);

  // results stay put while the host still holds req
  a_ack_hold: assert property (@(posedge clk) disable iff (!rst_n)
    ack && req |=> ack && $stable(nack) && $stable(rdata));

endmodule

/* rtl/eeprom_master_top.sv */
`timescale 1ns/10ps
module eeprom_master_top #(
  parameter int CLK_DIV = 4   // clk cycles per quarter scl period
) (
  input  logic                          clk,
  input  logic                          rst_n,
  input  logic                          req,
  input  logic                          wr,
  input  logic [eeprom_pkg::ADDR_W-1:0] addr,
  input  logic [7:0]                    wdata,
  output logic                          ack,
  output logic [7:0]                    rdata,
  output logic                          nack,
  output logic                          scl,
  inout  wire                           sda
);

  i2c_cmd_if cmd_if ();

  // transaction sequencing and host handshake
  eeprom_ctrl u_ctrl (
    .clk   (clk),
    .rst_n (rst_n),
    .req   (req),
    .wr    (wr),
    .addr  (addr),
    .wdata (wdata),
    .ack   (ack),
    .rdata (rdata),
    .nack  (nack),
    .bus   (cmd_if.ctrl)
  );

  i2c_bit_engine #(
    .CLK_DIV (CLK_DIV)
  ) u_engine (
    .clk   (clk),
    .rst_n (rst_n),
    .bus   (cmd_if.engine),
    .scl   (scl),
    .sda   (sda)
  );

endmodule

/* rtl/eeprom_pkg.sv */
package eeprom_pkg;

  // commands from the controller to the bit engine
  typedef enum logic [1:0] {
    CMD_START,       // start, or repeated start when the bus is busy
    CMD_STOP,
    CMD_WRITE_BYTE,
    CMD_READ_BYTE
  } i2c_cmd_e;

  // transaction sequence
  typedef enum logic [3:0] {
    IDLE,
    START_W,
    DEV_W,       // device select, write
    WORD_ADDR,
    DATA_W,
    START_R,     // repeated start
    DEV_R,       // device select, read
    DATA_R,
    STOP,
    ACKN         // holding ack for the host
  } ctrl_state_e;

  // 24C16 device type code
  localparam logic [3:0] EEPROM_DEV_ID = 4'b1010;

  // 2 K bytes, top three bits select the page
  localparam int ADDR_W = 11;

endpackage

/* rtl/i2c_bit_engine.sv */
`timescale 1ns/10ps
module i2c_bit_engine #(
  parameter int CLK_DIV = 4
) (
  input  logic      clk,
  input  logic      rst_n,
  i2c_cmd_if.engine bus,
  output logic      scl,
  inout  wire       sda
);

  localparam int DIV_W = $clog2(CLK_DIV);

  typedef enum logic [2:0] {
    ENG_IDLE,
    ENG_START,
    ENG_STOP,
    ENG_WRITE,
    ENG_READ
  } eng_state_e;

  eng_state_e       state;
  logic [DIV_W-1:0] div_cnt;   // clk cycles within a quarter
  logic [1:0]       quarter;   // quarter of the scl period
  logic [3:0]       bit_cnt;   // 0..7 data, 8 is the ack slot
  logic [7:0]       sh_q;
  logic             mack_q;
  logic             scl_q;
  logic             sda_oe;    // 1 pulls sda low
  logic             scl_nxt;
  logic             oe_nxt;
  logic             bit_oe;
  logic             q_end;
  logic             last_q;
  logic             rise;

  always_comb begin
    q_end = (div_cnt == DIV_W'(CLK_DIV - 1));
    rise  = (quarter == 2'd1) && (div_cnt == '0);
    last_q = 1'b0;
    if (q_end && quarter == 2'd3) begin
      case (state)
        ENG_START, ENG_STOP: last_q = 1'b1;
        ENG_WRITE, ENG_READ: last_q = (bit_cnt == 4'd8);
        default:             last_q = 1'b0;
      endcase
    end
  end

  // level wanted on sda for the current bit slot
  always_comb begin
    if (bit_cnt == 4'd8) begin
      bit_oe = (state == ENG_READ) ? !mack_q : 1'b0;  // release for the slave ack
    end else begin
      bit_oe = (state == ENG_WRITE) ? !sh_q[7] : 1'b0;
    end
  end

  always_comb begin
    scl_nxt = scl_q;
    oe_nxt  = sda_oe;
    case (state)
      ENG_START: begin
        scl_nxt = (quarter == 2'd0) ? scl_q : (quarter != 2'd3);
        oe_nxt  = quarter[1];     // sda falls in the middle of scl high
      end
      ENG_STOP: begin
        scl_nxt = (quarter != 2'd0);
        oe_nxt  = !quarter[1];    // sda rises with scl high
      end
      ENG_WRITE, ENG_READ: begin
        scl_nxt = (quarter == 2'd1) || (quarter == 2'd2);
        oe_nxt  = bit_oe;
      end
      default: ;
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state          <= ENG_IDLE;
      div_cnt        <= '0;
      quarter        <= 2'd0;
      bit_cnt        <= 4'd0;
      scl_q          <= 1'b1;
      sda_oe         <= 1'b0;
      bus.done       <= 1'b0;
      bus.slave_nack <= 1'b0;
    end else begin
      scl_q    <= scl_nxt;
      sda_oe   <= oe_nxt;
      bus.done <= last_q;
      if (state == ENG_IDLE) begin
        div_cnt <= '0;
        quarter <= 2'd0;
        bit_cnt <= 4'd0;
        if (bus.go) begin
          bus.slave_nack <= 1'b0;
          case (bus.cmd)
            eeprom_pkg::CMD_START:      state <= ENG_START;
            eeprom_pkg::CMD_STOP:       state <= ENG_STOP;
            eeprom_pkg::CMD_WRITE_BYTE: state <= ENG_WRITE;
            default:                    state <= ENG_READ;
          endcase
        end
      end else begin
        if (last_q) begin
          state <= ENG_IDLE;
        end
        if (q_end) begin
          div_cnt <= '0;
          quarter <= quarter + 1'b1;
          if (quarter == 2'd3) begin
            bit_cnt <= bit_cnt + 1'b1;
          end
        end else begin
          div_cnt <= div_cnt + 1'b1;
        end
        if (state == ENG_WRITE && rise && bit_cnt == 4'd8) begin
          bus.slave_nack <= sda;   // high means no ack
        end
      end
    end
  end

  // shared shift register, out on writes and in on reads
  always_ff @(posedge clk) begin
    if (state == ENG_IDLE && bus.go) begin
      sh_q   <= bus.tx_byte;
      mack_q <= bus.master_ack;
    end else if (state == ENG_WRITE && q_end && quarter == 2'd3) begin
      sh_q <= {sh_q[6:0], 1'b0};
    end else if (state == ENG_READ && rise && bit_cnt != 4'd8) begin
      sh_q <= {sh_q[6:0], sda};
    end
  end

  assign bus.rx_byte = sh_q;
  assign scl         = scl_q;
  assign sda         = sda_oe ? 1'b0 : 1'bz;

  // sda only moves with scl low, apart from start and stop
  a_sda_stable: assert property (@(posedge clk) disable iff (!rst_n)
    scl_q && $past(scl_q) && $changed(sda_oe) |-> $past(state) inside {ENG_START, ENG_STOP});

  a_done_pulse: assert property (@(posedge clk) disable iff (!rst_n)
    bus.done |=> !bus.done);

endmodule

/* rtl/i2c_cmd_if.sv */
`timescale 1ns/10ps
interface i2c_cmd_if;

  logic                 go;          // one-cycle command strobe
  eeprom_pkg::i2c_cmd_e cmd;
  logic [7:0]           tx_byte;
  logic                 master_ack;  // ninth bit after a read, 1 = nack
  logic                 done;        // one-cycle completion strobe
  logic [7:0]           rx_byte;
  logic                 slave_nack;

  modport ctrl (
    output go,
    output cmd,
    output tx_byte,
    output master_ack,
    input  done,
    input  rx_byte,
    input  slave_nack
  );

  modport engine (
    input  go,
    input  cmd,
    input  tx_byte,
    input  master_ack,
    output done,
    output rx_byte,
    output slave_nack
  );

endinterface

/* test/eeprom_checker.sv */
`timescale 1ns/10ps
module eeprom_checker (
  input  logic       clk,
  input  logic       rst_n,
  input  logic       req,
  input  logic       ack,
  input  logic [7:0] rdata,
  input  logic       nack,
  input  logic       scl,
  input  logic       exp_wr,
  input  logic [7:0] exp_rdata,
  input  logic       exp_nack,
  output int         errors
);

  logic ack_d = 1'b0;
  int   err_cnt = 0;

  assign errors = err_cnt;

  task automatic compare_result();
    if (nack !== exp_nack) begin
      err_cnt++;
      $display("FAILED at %0t: nack expected %0b, got %0b", $time, exp_nack, nack);
    end
    if (!exp_wr && !exp_nack && rdata !== exp_rdata) begin
      err_cnt++;
      $display("FAILED at %0t: rdata expected %02h, got %02h", $time, exp_rdata, rdata);
    end
  endtask

  // sampled mid cycle, away from the drive edge
  always @(negedge clk) begin
    if (!rst_n) begin
      if (ack !== 1'b0) begin
        err_cnt++;
        $display("ERROR at %0t: ack is not low during reset", $time);
      end
    end else begin
      if (ack === 1'b1 && ack_d === 1'b0 && req !== 1'b1) begin
        err_cnt++;
        $display("ERROR at %0t: ack rose while req was low", $time);
      end
      if (ack === 1'b0 && ack_d === 1'b1 && req !== 1'b0) begin
        err_cnt++;
        $display("ERROR at %0t: ack fell while req was still high", $time);
      end
      if ((ack === 1'b1 || req === 1'b0) && scl !== 1'b1) begin
        err_cnt++;
        $display("ERROR at %0t: scl is not high while the bus should be idle", $time);
      end
      if (ack === 1'b1 && ack_d === 1'b0) compare_result();
    end
    ack_d = ack;
  end

endmodule

/* test/eeprom_model.sv */
`timescale 1ns/10ps
module eeprom_model (
  input  wire  scl,
  inout  wire  sda,
  input  logic no_ack
);

  localparam int MEM_SIZE = 1 << eeprom_pkg::ADDR_W;

  logic [7:0]                    mem [MEM_SIZE];
  logic [eeprom_pkg::ADDR_W-1:0] ptr;
  logic [7:0]                    sh;
  logic [3:0]                    bit_cnt;    // scl rising edges in this byte
  logic [1:0]                    byte_idx;   // 0 device select, 1 word address, 2 data
  logic                          active;
  logic                          tx;         // slave is sending
  logic                          read_sel;   // read device select was acked
  logic                          master_nack;
  logic                          acked;
  logic                          sda_oe;
  logic                          scl_d;
  logic                          sda_d;

  assign sda = sda_oe ? 1'b0 : 1'bz;

  initial begin
    for (int i = 0; i < MEM_SIZE; i++) begin
      mem[i] = 8'hff;   // erased
    end
    ptr      = '0;
    sh       = 8'h00;
    bit_cnt  = 4'd0;
    byte_idx = 2'd0;
    active   = 1'b0;
    tx       = 1'b0;
    read_sel = 1'b0;
    sda_oe   = 1'b0;
    scl_d    = 1'b1;
    sda_d    = 1'b1;
  end

  // decide the ack for a received byte and act on it
  task automatic accept_byte();
    acked = (no_ack === 1'b0);
    case (byte_idx)
      2'd0: begin
        if (sh[7:4] != eeprom_pkg::EEPROM_DEV_ID) acked = 1'b0;
        if (acked) begin
          ptr[eeprom_pkg::ADDR_W-1 -: 3] = sh[3:1];   // page from device select
          read_sel = sh[0];
        end
      end
      2'd1: if (acked) ptr[7:0] = sh;
      default: begin
        if (acked) begin
          mem[ptr] = sh;   // committed at once
          ptr      = ptr + 1'b1;
        end
      end
    endcase
    if (acked && byte_idx != 2'd2) byte_idx = byte_idx + 1'b1;
    if (!acked) active = 1'b0;
    sda_oe = acked;
  endtask

  task automatic sample_bit();
    if (bit_cnt < 4'd8) begin
      if (!tx) sh = {sh[6:0], sda};
    end else if (bit_cnt == 4'd8 && tx) begin
      master_nack = (sda !== 1'b0);
    end
    bit_cnt = bit_cnt + 1'b1;
  endtask

  task automatic drive_bit();
    if (bit_cnt == 4'd8) begin
      if (tx) sda_oe = 1'b0;   // let the master answer
      else accept_byte();
    end else if (bit_cnt == 4'd9) begin
      bit_cnt = 4'd0;
      sda_oe  = 1'b0;
      if (tx && master_nack) begin
        tx = 1'b0;
      end else if (!tx && read_sel) begin
        tx       = 1'b1;
        read_sel = 1'b0;
      end
      if (tx) begin
        sh     = mem[ptr];
        ptr    = ptr + 1'b1;
        sda_oe = !sh[7];
      end
    end else if (tx && bit_cnt != 4'd0) begin
      sda_oe = !sh[7 - bit_cnt];
    end
  endtask

  always @(scl or sda) begin
    if (scl === 1'b1 && scl_d === 1'b1 && sda_d === 1'b1 && sda === 1'b0) begin
      active   = 1'b1;   // start or repeated start
      tx       = 1'b0;
      read_sel = 1'b0;
      bit_cnt  = 4'd0;
      byte_idx = 2'd0;
      sda_oe   = 1'b0;
    end else if (scl === 1'b1 && scl_d === 1'b1 && sda_d === 1'b0 && sda === 1'b1) begin
      active = 1'b0;     // stop
      tx     = 1'b0;
      sda_oe = 1'b0;
    end else if (active && scl_d === 1'b0 && scl === 1'b1) begin
      sample_bit();
    end else if (active && scl_d === 1'b1 && scl === 1'b0) begin
      drive_bit();
    end
    scl_d = scl;
    sda_d = sda;
  end

endmodule

/* test/tb_eeprom_master.sv */
`timescale 1ns/10ps
module tb_eeprom_master;

  localparam int WAIT_LIMIT = 2000;

  typedef struct packed {
    logic                          wr;
    logic [eeprom_pkg::ADDR_W-1:0] addr;
    logic [7:0]                    wdata;
    logic                          no_ack;
    logic [7:0]                    exp_rdata;
    logic                          exp_nack;
  } stim_t;

  logic                          clk;
  logic                          rst_n;
  logic                          req;
  logic                          wr;
  logic [eeprom_pkg::ADDR_W-1:0] addr;
  logic [7:0]                    wdata;
  logic                          no_ack;
  logic                          exp_wr;
  logic [7:0]                    exp_rdata;
  logic                          exp_nack;
  logic                          ack;
  logic [7:0]                    rdata;
  logic                          nack;
  tri1                           scl;
  tri1                           sda;
  int                            errors;
  int                            timeouts = 0;
  int                            done_cnt = 0;
  integer                        seed = 32'h3c37;
  stim_t                         stim_q[$];

  eeprom_master_top #(
    .CLK_DIV (4)
  ) u_eeprom_master_top (
    .clk   (clk),
    .rst_n (rst_n),
    .req   (req),
    .wr    (wr),
    .addr  (addr),
    .wdata (wdata),
    .ack   (ack),
    .rdata (rdata),
    .nack  (nack),
    .scl   (scl),
    .sda   (sda)
  );

  eeprom_model u_model (
    .scl    (scl),
    .sda    (sda),
    .no_ack (no_ack)
  );

  eeprom_checker u_checker (
    .clk       (clk),
    .rst_n     (rst_n),
    .req       (req),
    .ack       (ack),
    .rdata     (rdata),
    .nack      (nack),
    .scl       (scl),
    .exp_wr    (exp_wr),
    .exp_rdata (exp_rdata),
    .exp_nack  (exp_nack),
    .errors    (errors)
  );

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  task automatic add_entry(input logic op_wr, input logic [eeprom_pkg::ADDR_W-1:0] where,
                           input logic [7:0] data, input logic refuse,
                           input logic [7:0] rd_expect, input logic nack_expect);
    stim_t s;
    s.wr        = op_wr;
    s.addr      = where;
    s.wdata     = data;
    s.no_ack    = refuse;
    s.exp_rdata = rd_expect;
    s.exp_nack  = nack_expect;
    stim_q.push_back(s);
  endtask

  task automatic build_table();
    logic [7:0] rnd;
    rnd = 8'($random(seed));
    add_entry(1'b1, 11'h025, 8'h5a, 1'b0, 8'h00, 1'b0);
    add_entry(1'b0, 11'h025, 8'h00, 1'b0, 8'h5a, 1'b0);   // read back
    add_entry(1'b1, 11'h125, 8'ha3, 1'b0, 8'h00, 1'b0);   // same word, other pages
    add_entry(1'b1, 11'h725, 8'h3c, 1'b0, 8'h00, 1'b0);
    add_entry(1'b0, 11'h025, 8'h00, 1'b0, 8'h5a, 1'b0);
    add_entry(1'b0, 11'h125, 8'h00, 1'b0, 8'ha3, 1'b0);
    add_entry(1'b0, 11'h725, 8'h00, 1'b0, 8'h3c, 1'b0);
    add_entry(1'b0, 11'h3f0, 8'h00, 1'b0, 8'hff, 1'b0);   // never written
    add_entry(1'b1, 11'h125, 8'h77, 1'b1, 8'h00, 1'b1);   // slave refuses
    add_entry(1'b0, 11'h125, 8'h00, 1'b1, 8'h00, 1'b1);
    add_entry(1'b0, 11'h125, 8'h00, 1'b0, 8'ha3, 1'b0);   // aborted write left no trace
    add_entry(1'b1, 11'h4c1, rnd,   1'b0, 8'h00, 1'b0);
    add_entry(1'b0, 11'h4c1, 8'h00, 1'b0, rnd,   1'b0);
  endtask

  // samples on the falling edge, where ack is settled
  task automatic wait_ack(input logic level, output logic ok);
    int cnt;
    cnt = 0;
    ok  = 1'b1;
    @(negedge clk);
    while (ack !== level && cnt < WAIT_LIMIT) begin
      @(negedge clk);
      cnt++;
    end
    if (ack !== level) begin
      ok = 1'b0;
      timeouts++;
      $display("ERROR at %0t: timeout waiting for ack to go %0b", $time, level);
    end
  endtask

  task automatic run_entry(input stim_t s, output logic ok);
    @(posedge clk);
    req       <= 1'b1;
    wr        <= s.wr;
    addr      <= s.addr;
    wdata     <= s.wdata;
    no_ack    <= s.no_ack;
    exp_wr    <= s.wr;
    exp_rdata <= s.exp_rdata;
    exp_nack  <= s.exp_nack;
    wait_ack(1'b1, ok);
    if (ok) begin
      @(posedge clk);
      req <= 1'b0;
      wait_ack(1'b0, ok);
      done_cnt++;
    end
  endtask

  initial begin
    int   i;
    logic ok;
    rst_n     = 1'b0;
    req       = 1'b0;
    wr        = 1'b0;
    addr      = '0;
    wdata     = 8'h00;
    no_ack    = 1'b0;
    exp_wr    = 1'b0;
    exp_rdata = 8'h00;
    exp_nack  = 1'b0;
    build_table();
    repeat (5) @(posedge clk);
    rst_n <= 1'b1;
    ok = 1'b1;
    for (i = 0; i < stim_q.size() && ok; i++) begin
      run_entry(stim_q[i], ok);
    end
    repeat (4) @(posedge clk);
    $display("transactions %0d, check errors %0d, timeouts %0d", done_cnt, errors, timeouts);
    if (errors == 0 && timeouts == 0) begin
      $display("ALL TESTS PASSED");
    end else begin
      $display("SOME TESTS FAILED");
    end
    $finish;
  end

endmodule

/* vlog.f */
rtl/eeprom_pkg.sv
rtl/i2c_cmd_if.sv
rtl/i2c_bit_engine.sv
rtl/eeprom_ctrl.sv
rtl/eeprom_master_top.sv
test/eeprom_model.sv
test/eeprom_checker.sv
test/tb_eeprom_master.sv
